// File: rtl/cpu_bus_if.sv
// Z80 side cartridge bus as seen by the slot
interface cpu_bus_if;

    logic [15:0] addr;   // CPU address
    logic [7:0]  wdata;  // CPU write data
    logic        wr;     // Write strobe, level
    logic        rd;     // Read strobe, level
    logic        sltsl;  // Slot select for this cartridge

    // Mappers only observe the bus
    modport device (
        input addr,
        input wdata,
        input wr,
        input rd,
        input sltsl
    );

endinterface

// File: rtl/mapper_ascii16.sv
`include "msx_mapper_defines.svh"

module mapper_ascii16
    import msx_mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    cpu_bus_if.device   cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out
);

    logic [`MSX_PAGE_W-2:0] bank0;   // 16 KB bank for 4000h..7FFFh
    logic [`MSX_PAGE_W-2:0] bank1;   // 16 KB bank for 8000h..BFFFh
    logic                   sel;
    logic                   wr_hit;  // Slot write while selected
    logic                   active;
    logic [`MSX_PAGE_W-2:0] bank;    // Bank for the current read
    logic [`MSX_PAGE_W-1:0] page;    // 8 KB page, masked

    assign sel    = (block_info.typ == MAP_ASCII16);
    assign wr_hit = sel && cpu_bus.wr && cpu_bus.sltsl;

    // 6800h and 7800h ranges are not decoded
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank0 <= '0;
            bank1 <= '0;
        end else if (wr_hit) begin
            if (cpu_bus.addr[15:11] == 5'b01100) bank0 <= cpu_bus.wdata[`MSX_PAGE_W-2:0];
            if (cpu_bus.addr[15:11] == 5'b01110) bank1 <= cpu_bus.wdata[`MSX_PAGE_W-2:0];
        end
    end

    assign active = sel && cpu_bus.rd && cpu_bus.sltsl &&
                    (cpu_bus.addr >= `MSX_WIN_LO) && (cpu_bus.addr <= `MSX_WIN_HI);

    assign bank = cpu_bus.addr[15] ? bank1 : bank0;  // Upper half of window uses bank 1

    // Twice the bank, plus one for the upper 8 KB of the 16 KB page
    assign page = {bank, cpu_bus.addr[13]} & block_info.page_mask;

    always_comb begin
        out.addr   = '1;
        out.rom_cs = 1'b0;
        if (active) begin
            out.addr   = {page, cpu_bus.addr[12:0]};
            out.rom_cs = 1'b1;
        end
    end

endmodule

// File: rtl/mapper_ascii8.sv
`include "msx_mapper_defines.svh"

module mapper_ascii8
    import msx_mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    cpu_bus_if.device   cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out
);

    logic [`MSX_PAGE_W-1:0] bank [4];  // One register per 8 KB CPU page
    logic                   sel;       // This mapper is the configured one
    logic                   bank_we;   // Write into 6000h..7FFFh
    logic [1:0]             wr_idx;    // Register addressed by the write
    logic [1:0]             rd_idx;    // CPU page being read
    logic                   active;    // Read hits this mapper
    logic [`MSX_PAGE_W-1:0] page;      // Masked ROM page

    assign sel = (block_info.typ == MAP_ASCII8);

    // 800h wide register ranges starting at 6000h
    assign bank_we = sel && cpu_bus.wr && cpu_bus.sltsl && (cpu_bus.addr[15:13] == 3'b011);
    assign wr_idx  = cpu_bus.addr[12:11];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                bank[i] <= '0;
            end
        end else if (bank_we) begin
            bank[wr_idx] <= cpu_bus.wdata[`MSX_PAGE_W-1:0];  // Low 7 bits kept
        end
    end

    // 4000h->0, 6000h->1, 8000h->2, A000h->3 inside the window
    assign rd_idx = {cpu_bus.addr[15], cpu_bus.addr[13]};

    assign active = sel && cpu_bus.rd && cpu_bus.sltsl &&
                    (cpu_bus.addr >= `MSX_WIN_LO) && (cpu_bus.addr <= `MSX_WIN_HI);

    assign page = bank[rd_idx] & block_info.page_mask;  // Wrap to ROM size

    always_comb begin
        out.addr   = '1;
        out.rom_cs = 1'b0;
        if (active) begin
            out.addr   = {page, cpu_bus.addr[12:0]};  // Page plus 8 KB offset
            out.rom_cs = 1'b1;
        end
    end

endmodule

// File: rtl/mapper_cfg_regs.sv
`include "msx_mapper_defines.svh"

module mapper_cfg_regs
    import msx_mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cfg_wr,      // Register write strobe
    input  logic        cfg_sel,     // 0 selects type, 1 selects page mask
    input  logic [7:0]  cfg_wdata,
    output block_info_t block_info
);

    mapper_t                typ_q;   // Active mapper type
    logic [`MSX_PAGE_W-1:0] mask_q;  // ROM page mask

    // Type and mask registers
    // Bank registers in the mappers are left alone on a type change
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            typ_q  <= MAP_PLAIN;  // Plain mapper out of reset
            mask_q <= '1;         // Full 1 MB, no wrap
        end else if (cfg_wr) begin
            if (cfg_sel) begin
                mask_q <= cfg_wdata[`MSX_PAGE_W-1:0];  // Low 7 bits
            end else begin
                typ_q  <= mapper_t'(cfg_wdata[1:0]);   // Low 2 bits
            end
        end
    end

    // Drive both fields as one struct
    always_comb begin
        block_info.typ       = typ_q;
        block_info.page_mask = mask_q;
    end

endmodule

// File: rtl/mapper_konami.sv
`include "msx_mapper_defines.svh"

module mapper_konami
    import msx_mapper_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    cpu_bus_if.device   cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out
);

    logic [`MSX_PAGE_W-1:0] bank1;   // Page at 6000h
    logic [`MSX_PAGE_W-1:0] bank2;   // Page at 8000h
    logic [`MSX_PAGE_W-1:0] bank3;   // Page at A000h
    logic                   sel;
    logic                   wr_hit;
    logic                   active;
    logic [`MSX_PAGE_W-1:0] bank;    // Unmasked page for the read
    logic [`MSX_PAGE_W-1:0] page;

    assign sel    = (block_info.typ == MAP_KONAMI);
    assign wr_hit = sel && cpu_bus.wr && cpu_bus.sltsl;

    // Each switchable page is written anywhere inside its own 8 KB range
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bank1 <= 7'd1;  // Power-on layout is linear
            bank2 <= 7'd2;
            bank3 <= 7'd3;
        end else if (wr_hit) begin
            case (cpu_bus.addr[15:13])
                3'b011:  bank1 <= cpu_bus.wdata[`MSX_PAGE_W-1:0];
                3'b100:  bank2 <= cpu_bus.wdata[`MSX_PAGE_W-1:0];
                3'b101:  bank3 <= cpu_bus.wdata[`MSX_PAGE_W-1:0];
                default: ;  // Writes to 4000h page ignored
            endcase
        end
    end

    assign active = sel && cpu_bus.rd && cpu_bus.sltsl &&
                    (cpu_bus.addr >= `MSX_WIN_LO) && (cpu_bus.addr <= `MSX_WIN_HI);

    always_comb begin
        case (cpu_bus.addr[15:13])
            3'b010:  bank = '0;     // Fixed first page
            3'b011:  bank = bank1;
            3'b100:  bank = bank2;
            default: bank = bank3;  // A000h, window already checked
        endcase
    end

    assign page = bank & block_info.page_mask;

    always_comb begin
        out.addr   = '1;
        out.rom_cs = 1'b0;
        if (active) begin
            out.addr   = {page, cpu_bus.addr[12:0]};
            out.rom_cs = 1'b1;
        end
    end

endmodule

// File: rtl/mapper_plain.sv
`include "msx_mapper_defines.svh"

module mapper_plain
    import msx_mapper_pkg::*;
(
    cpu_bus_if.device   cpu_bus,
    input  block_info_t block_info,
    output mapper_out_t out
);

    logic                   active;    // Read hits this mapper
    logic [15:0]            rel_addr;  // Offset inside the window
    logic [`MSX_PAGE_W-1:0] page;      // Masked 8 KB page number

    assign active = (block_info.typ == MAP_PLAIN) && cpu_bus.rd && cpu_bus.sltsl &&
                    (cpu_bus.addr >= `MSX_WIN_LO) && (cpu_bus.addr <= `MSX_WIN_HI);

    // ROM address is the CPU address minus 4000h
    assign rel_addr = cpu_bus.addr - `MSX_WIN_LO;

    // Only pages 0..3 reachable, still wrapped by the mask
    assign page = {4'b0000, rel_addr[15:13]} & block_info.page_mask;

    always_comb begin
        out.addr   = '1;    // Idle, neutral for the AND merge
        out.rom_cs = 1'b0;
        if (active) begin
            out.addr   = {page, rel_addr[12:0]};
            out.rom_cs = 1'b1;
        end
    end

endmodule

// File: rtl/mappers.sv
`include "msx_mapper_defines.svh"

module mappers
    import msx_mapper_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    cpu_bus_if.device              cpu_bus,
    input  block_info_t            block_info,
    input  logic [7:0]             rom_rdata,  // Byte from ROM at rom_addr
    output logic [`MSX_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    output logic [7:0]             cpu_rdata   // FFh when no mapper answers
);

    mapper_out_t plain_out;    // Linear mapper result
    mapper_out_t ascii8_out;   // ASCII8 result
    mapper_out_t ascii16_out;  // ASCII16 result
    mapper_out_t konami_out;   // Konami result

    // No banking, no registers
    mapper_plain plain (
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (plain_out)
    );

    mapper_ascii8 ascii8 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (ascii8_out)
    );

    mapper_ascii16 ascii16 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (ascii16_out)
    );

    mapper_konami konami (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus),
        .block_info (block_info),
        .out        (konami_out)
    );

    // Idle mappers drive all ones, so AND leaves the active address
    assign rom_addr = plain_out.addr & ascii8_out.addr & ascii16_out.addr & konami_out.addr;

    // At most one chip select is high
    assign rom_cs = plain_out.rom_cs | ascii8_out.rom_cs | ascii16_out.rom_cs | konami_out.rom_cs;

    // Open bus reads back as FFh
    assign cpu_rdata = rom_cs ? rom_rdata : 8'hFF;

endmodule

// File: rtl/msx_cart_top.sv
`include "msx_mapper_defines.svh"

module msx_cart_top
    import msx_mapper_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [15:0]            cpu_addr,
    input  logic [7:0]             cpu_wdata,
    input  logic                   cpu_wr,
    input  logic                   cpu_rd,
    input  logic                   cpu_sltsl,
    input  logic                   cfg_wr,
    input  logic                   cfg_sel,
    input  logic [7:0]             cfg_wdata,
    input  logic [7:0]             rom_rdata,
    output logic [`MSX_ROM_AW-1:0] rom_addr,
    output logic                   rom_cs,
    output logic [7:0]             cpu_rdata
);

    cpu_bus_if   cpu_bus ();  // Bundled CPU side signals
    block_info_t block_info;  // Active type and page mask

    assign cpu_bus.addr  = cpu_addr;
    assign cpu_bus.wdata = cpu_wdata;
    assign cpu_bus.wr    = cpu_wr;
    assign cpu_bus.rd    = cpu_rd;
    assign cpu_bus.sltsl = cpu_sltsl;

    mapper_cfg_regs cfg_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .cfg_wr     (cfg_wr),
        .cfg_sel    (cfg_sel),
        .cfg_wdata  (cfg_wdata),
        .block_info (block_info)
    );

    mappers mappers (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_bus    (cpu_bus.device),
        .block_info (block_info),
        .rom_rdata  (rom_rdata),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .cpu_rdata  (cpu_rdata)
    );

endmodule

// File: rtl/msx_mapper_defines.svh
`ifndef MSX_MAPPER_DEFINES_SVH
`define MSX_MAPPER_DEFINES_SVH

// ROM side address width, 1 MB image
`define MSX_ROM_AW 20

// 8 KB page number width, 128 pages of 8 KB fill the ROM space
`define MSX_PAGE_W 7

// CPU window served by the cartridge ROM
`define MSX_WIN_LO 16'h4000  // First mapped CPU address
`define MSX_WIN_HI 16'hBFFF  // Last mapped CPU address

`endif

// File: rtl/msx_mapper_pkg.sv
`include "msx_mapper_defines.svh"

package msx_mapper_pkg;

    // Mapper emulation selected by the configuration block
    typedef enum logic [1:0] {
        MAP_PLAIN   = 2'd0,  // Linear ROM, no banking
        MAP_ASCII8  = 2'd1,  // Four 8 KB banks
        MAP_ASCII16 = 2'd2,  // Two 16 KB banks
        MAP_KONAMI  = 2'd3   // Page 0 fixed, three 8 KB banks
    } mapper_t;

    // Block configuration shared by all mappers
    typedef struct packed {
        mapper_t                typ;        // Active mapper
        logic [`MSX_PAGE_W-1:0] page_mask;  // Wraps page numbers to the ROM size
    } block_info_t;

    // Per-mapper result, merged in mappers
    // Idle mapper drives addr all ones and rom_cs low
    typedef struct packed {
        logic [`MSX_ROM_AW-1:0] addr;    // ROM byte address
        logic                   rom_cs;  // ROM chip select
    } mapper_out_t;

endpackage

// File: tb.f
+incdir+rtl
rtl/msx_mapper_pkg.sv
rtl/cpu_bus_if.sv
rtl/mapper_cfg_regs.sv
rtl/mapper_plain.sv
rtl/mapper_ascii8.sv
rtl/mapper_ascii16.sv
rtl/mapper_konami.sv
rtl/mappers.sv
rtl/msx_cart_top.sv
verif/tb_msx_cart.sv

// File: verif/tb_msx_cart.sv
`include "msx_mapper_defines.svh"

module tb_msx_cart
    import msx_mapper_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_PLAIN  = 200;  // Reads and ignored writes in plain mode
    localparam int N_MAPPER = 300;  // Per banked mapper
    localparam int N_MASK   = 150;  // Per mapper with a small mask
    localparam int N_SWITCH = 12;   // Type changes in the last phase
    localparam int N_RUN    = 40;   // Accesses between type changes
    localparam int PLANNED  = 2 + N_PLAIN + 3 * (1 + N_MAPPER) + 4 * (2 + N_MASK) +
                              1 + N_SWITCH * (1 + N_RUN);
    localparam int TIMEOUT  = 4 * PLANNED;

    logic                   clk;
    logic                   rst_n;
    logic [15:0]            cpu_addr;
    logic [7:0]             cpu_wdata;
    logic                   cpu_wr;
    logic                   cpu_rd;
    logic                   cpu_sltsl;
    logic                   cfg_wr;
    logic                   cfg_sel;
    logic [7:0]             cfg_wdata;
    logic [7:0]             rom_rdata;
    logic [`MSX_ROM_AW-1:0] rom_addr;
    logic                   rom_cs;
    logic [7:0]             cpu_rdata;

    logic [31:0] lfsr = 32'hca5f_1023;  // Random source state
    int          cycle_cnt = 0;
    mapper_t     m_typ;                 // Model of the configuration
    logic [6:0]  m_mask;
    logic [6:0]  m_a8 [4];              // Model ASCII8 banks
    logic [5:0]  m_a16 [2];             // Model ASCII16 banks
    logic [6:0]  m_kon [4];             // Model Konami pages with entry 0 fixed at 0

    msx_cart_top u_dut (.*);

    always #5 clk = ~clk;

    // ROM content is the low address byte XOR the next one
    function automatic logic [7:0] rom_byte(input logic [`MSX_ROM_AW-1:0] a);
        return a[7:0] ^ a[15:8];
    endfunction

    assign rom_rdata = rom_byte(rom_addr);

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // Expected {rom_cs, rom_addr} for a CPU access
    function automatic logic [20:0] predict(input logic [15:0] a, input logic rd,
                                            input logic sl);
        logic [15:0] rel;
        logic [1:0]  k;     // 8 KB page inside the window
        logic [6:0]  pg;
        if (!(rd && sl && a >= 16'h4000 && a <= 16'hBFFF)) return {1'b0, 20'hFFFFF};
        rel = a - 16'h4000;
        k   = rel[14:13];
        case (m_typ)
            MAP_PLAIN:   pg = {5'd0, k};
            MAP_ASCII8:  pg = m_a8[k];
            MAP_ASCII16: pg = {m_a16[k[1]], k[0]};  // Twice the bank plus 1 for the upper half
            default:     pg = m_kon[k];
        endcase
        return {1'b1, pg & m_mask, a[12:0]};
    endfunction

    // Bank register update of the model for a slot write
    task automatic model_write(input logic [15:0] a, input logic [7:0] wd);
        case (m_typ)
            MAP_ASCII8: if (a >= 16'h6000 && a <= 16'h7FFF) m_a8[(a - 16'h6000) >> 11] = wd[6:0];
            MAP_ASCII16: begin
                if (a >= 16'h6000 && a <= 16'h67FF) m_a16[0] = wd[5:0];
                if (a >= 16'h7000 && a <= 16'h77FF) m_a16[1] = wd[5:0];
            end
            MAP_KONAMI: if (a >= 16'h6000 && a <= 16'hBFFF) m_kon[(a - 16'h4000) >> 13] = wd[6:0];
            default: ;  // Plain has no banks
        endcase
    endtask

    task automatic check_addr(input logic [`MSX_ROM_AW-1:0] exp,
                              input logic [`MSX_ROM_AW-1:0] act);
        if (act !== exp) begin
            $display("FAIL rom_addr expected %h got %h", exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_cs(input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL rom_cs expected %h got %h", exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_data(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAIL cpu_rdata expected %h got %h", exp, act);
            $display("Simulation FAILED");
            $fatal(1);
        end
    endtask

    // One CPU cycle checked late in the cycle with the model updated at the sampling edge
    task automatic bus_cycle(input logic [15:0] a, input logic [7:0] wd, input logic wr,
                             input logic rd, input logic sl);
        logic [20:0] exp;
        @(posedge clk);
        #1;
        cpu_addr  = a;
        cpu_wdata = wd;
        cpu_wr    = wr;
        cpu_rd    = rd;
        cpu_sltsl = sl;
        cfg_wr    = 1'b0;
        #6;
        exp = predict(a, rd, sl);
        check_cs(exp[20], rom_cs);
        check_addr(exp[19:0], rom_addr);
        check_data(exp[20] ? rom_byte(exp[19:0]) : 8'hFF, cpu_rdata);
        if (wr && sl) model_write(a, wd);
    endtask

    task automatic cfg_write(input logic sel, input logic [7:0] d);
        @(posedge clk);
        #1;
        cfg_wr    = 1'b1;
        cfg_sel   = sel;
        cfg_wdata = d;
        cpu_wr    = 1'b0;
        cpu_rd    = 1'b0;
        if (sel) m_mask = d[6:0];
        else m_typ = mapper_t'(d[1:0]);
    endtask

    // Mix of window writes, deselected reads, stray reads, deselected writes and window reads
    task automatic run_random(input int n);
        logic [2:0]  kind;
        logic [15:0] a;
        for (int i = 0; i < n; i++) begin
            kind = 3'(rand_bits(3));
            a    = 16'h4000 + 16'(rand_bits(15));  // Inside 4000h..BFFFh
            if (kind == 3'd0) bus_cycle(a, 8'(rand_bits(8)), 1'b1, 1'b0, 1'b1);
            else if (kind == 3'd1) bus_cycle(16'(rand_bits(16)), 8'h00, 1'b0, 1'b1, 1'b0);
            else if (kind == 3'd2) bus_cycle(16'(rand_bits(16)), 8'h00, 1'b0, 1'b1, 1'b1);
            else if (kind == 3'd3) bus_cycle(a, 8'(rand_bits(8)), 1'b1, 1'b0, 1'b0);
            else bus_cycle(a, 8'h00, 1'b0, 1'b1, 1'b1);
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wr    = 1'b0;
        cpu_rd    = 1'b0;
        cpu_sltsl = 1'b0;
        cfg_wr    = 1'b0;
        cfg_sel   = 1'b0;
        cfg_wdata = '0;
        m_typ  = MAP_PLAIN;  // Reset state of the model
        m_mask = 7'h7F;
        m_a8   = '{default: 7'd0};
        m_a16  = '{default: 6'd0};
        m_kon  = '{7'd0, 7'd1, 7'd2, 7'd3};
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
        run_random(N_PLAIN);                        // Plain after reset
        cfg_write(1'b0, MAP_ASCII8);
        run_random(N_MAPPER);
        cfg_write(1'b0, MAP_ASCII16);
        run_random(N_MAPPER);
        cfg_write(1'b0, MAP_KONAMI);                // Banks still at 1, 2, 3
        run_random(N_MAPPER);
        for (int t = 0; t < 4; t++) begin
            cfg_write(1'b1, 8'(rand_bits(3)));      // Small mask that wraps pages
            cfg_write(1'b0, 8'(t));
            run_random(N_MASK);
        end
        cfg_write(1'b1, 8'h7F);
        for (int s = 0; s < N_SWITCH; s++) begin
            cfg_write(1'b0, 8'(rand_bits(2)));      // Banks survive the switch
            run_random(N_RUN);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule
